// File: nlb_pkg.sv
package nlb_pkg;

   // --------------------
   // Data widths
   // --------------------

   // Host-side cache line address and payload
   typedef logic [31:0]  cl_addr_t;
   typedef logic [511:0] cl_data_t;

   // Line count, also used as line index
   typedef logic [15:0]  cl_count_t;

   // Request metadata, carries the line index
   typedef logic [15:0]  req_tid_t;

   // MMIO side
   typedef logic [15:0]  csr_addr_t;
   typedef logic [63:0]  csr_data_t;
   typedef logic [8:0]   mmio_tid_t;

   // --------------------
   // CSR map
   // --------------------

   localparam csr_addr_t CSR_SCRATCH    = 16'h0100;
   localparam csr_addr_t CSR_SRC_ADDR   = 16'h0120;
   localparam csr_addr_t CSR_DST_ADDR   = 16'h0128;
   localparam csr_addr_t CSR_NUM_LINES  = 16'h0130;
   localparam csr_addr_t CSR_CTL        = 16'h0138;
   localparam csr_addr_t CSR_CFG        = 16'h0140;
   localparam csr_addr_t CSR_STATUS     = 16'h0160;
   localparam csr_addr_t CSR_NUM_READS  = 16'h0168;
   localparam csr_addr_t CSR_NUM_WRITES = 16'h0170;

   // CTL register fields
   localparam int CTL_RUN_N_BIT = 0;
   localparam int CTL_START_BIT = 1;

   // --------------------
   // Encodings
   // --------------------

   // Test mode, CFG bits 4 to 2
   typedef enum logic [2:0]
   {
      MODE_LPBK1 = 3'd0,
      MODE_READ  = 3'd1,
      MODE_WRITE = 3'd2,
      MODE_TRPUT = 3'd3
   } test_mode_e;

   typedef enum logic [1:0]
   {
      ST_IDLE,
      ST_RUN,
      ST_DONE
   } engine_state_e;

   // --------------------
   // Channel structs
   // --------------------

   typedef struct packed
   {
      logic      wr_valid;
      logic      rd_valid;
      csr_addr_t addr;
      mmio_tid_t tid;
      csr_data_t data;
   } mmio_req_t;

   typedef struct packed
   {
      logic      valid;
      mmio_tid_t tid;
      csr_data_t data;
   } mmio_rsp_t;

   typedef struct packed
   {
      logic     valid;
      cl_addr_t addr;
      req_tid_t tid;
   } rd_req_t;

   typedef struct packed
   {
      logic     valid;
      cl_addr_t addr;
      req_tid_t tid;
      cl_data_t data;
   } wr_req_t;

   typedef struct packed
   {
      logic     valid;
      req_tid_t tid;
      cl_data_t data;
   } rd_rsp_t;

   typedef struct packed
   {
      logic     valid;
      req_tid_t tid;
   } wr_rsp_t;

   // Register image handed from CSR block to engine
   typedef struct packed
   {
      cl_addr_t   src;
      cl_addr_t   dst;
      cl_count_t  num_lines;
      test_mode_e mode;
      logic       run_n;
      logic       start;
   } test_cfg_t;

   // Engine to requestor, held until the matching sent pulse
   typedef struct packed
   {
      logic     rd_en;
      cl_addr_t rd_addr;
      req_tid_t rd_tid;
      logic     wr_en;
      cl_addr_t wr_addr;
      req_tid_t wr_tid;
      cl_data_t wr_data;
   } engine_req_t;

endpackage

// File: nlb_csr.sv
`timescale 1ns/100ps

module nlb_csr
(
   input  logic               Clk_400,
   input  logic               reset,
   input  nlb_pkg::mmio_req_t mmio_req,
   output nlb_pkg::mmio_rsp_t mmio_rsp,
   output nlb_pkg::test_cfg_t cfg,
   input  logic               running,
   input  logic               test_done,
   input  nlb_pkg::csr_data_t num_reads,
   input  nlb_pkg::csr_data_t num_writes
);

   import nlb_pkg::*;

   // Register storage
   csr_data_t  scratch;
   cl_addr_t   src_addr;
   cl_addr_t   dst_addr;
   cl_count_t  num_lines;
   test_mode_e mode;
   logic       run_n;
   logic       start;

   // Read-back mux output
   csr_data_t  rd_data;

   // --------------------
   // Register writes
   // --------------------

   // Write lands on the edge after wr_valid
   // Test setup is frozen while the engine runs
   always_ff @(posedge Clk_400)
   begin
      if (reset)
      begin
         scratch   <= '0;
         src_addr  <= '0;
         dst_addr  <= '0;
         num_lines <= '0;
         mode      <= MODE_LPBK1;
         run_n     <= 1'b0;
         start     <= 1'b0;
      end
      else if (mmio_req.wr_valid)
      begin
         case (mmio_req.addr)
            CSR_SCRATCH:
            begin
               scratch <= mmio_req.data;
            end
            CSR_SRC_ADDR:
            begin
               if (!running)
                  src_addr <= mmio_req.data[31:0];
            end
            CSR_DST_ADDR:
            begin
               if (!running)
                  dst_addr <= mmio_req.data[31:0];
            end
            CSR_NUM_LINES:
            begin
               if (!running)
                  num_lines <= mmio_req.data[15:0];
            end
            CSR_CTL:
            begin
               // Control stays writable, so software can stop a run
               run_n <= mmio_req.data[CTL_RUN_N_BIT];
               start <= mmio_req.data[CTL_START_BIT];
            end
            CSR_CFG:
            begin
               if (!running)
                  mode <= test_mode_e'(mmio_req.data[4:2]);
            end
            default:
            begin
            end
         endcase
      end
   end

   // Register image to the engine
   always_comb
   begin
      cfg.src       = src_addr;
      cfg.dst       = dst_addr;
      cfg.num_lines = num_lines;
      cfg.mode      = mode;
      cfg.run_n     = run_n;
      cfg.start     = start;
   end

   // --------------------
   // Register reads
   // --------------------

   always_comb
   begin
      case (mmio_req.addr)
         CSR_SCRATCH:    rd_data = scratch;
         CSR_SRC_ADDR:   rd_data = {32'h0, src_addr};
         CSR_DST_ADDR:   rd_data = {32'h0, dst_addr};
         CSR_NUM_LINES:  rd_data = {48'h0, num_lines};
         CSR_CTL:        rd_data = {62'h0, start, run_n};
         CSR_CFG:        rd_data = {59'h0, mode, 2'b00};
         // Bit 0 completion flag, bit 1 busy
         CSR_STATUS:     rd_data = {62'h0, running, test_done};
         CSR_NUM_READS:  rd_data = num_reads;
         CSR_NUM_WRITES: rd_data = num_writes;
         default:        rd_data = '0;
      endcase
   end

   // Response one cycle after rd_valid, tid echoed back
   always_ff @(posedge Clk_400)
   begin
      mmio_rsp.tid  <= mmio_req.tid;
      mmio_rsp.data <= rd_data;
      if (reset)
         mmio_rsp.valid <= 1'b0;
      else
         mmio_rsp.valid <= mmio_req.rd_valid;
   end

endmodule

// File: nlb_requestor.sv
`timescale 1ns/100ps

module nlb_requestor
(
   input  logic                 Clk_400,
   input  logic                 reset,
   input  nlb_pkg::engine_req_t req,
   output logic                 rd_sent,
   output logic                 wr_sent,
   output nlb_pkg::rd_req_t     tx_rd,
   output nlb_pkg::wr_req_t     tx_wr,
   input  nlb_pkg::rd_rsp_t     rx_rd,
   input  nlb_pkg::wr_rsp_t     rx_wr,
   output nlb_pkg::rd_rsp_t     rd_rsp,
   output nlb_pkg::wr_rsp_t     wr_rsp,
   input  logic                 rd_alm_full,
   input  logic                 wr_alm_full,
   input  logic                 test_reset,
   output nlb_pkg::csr_data_t   num_reads,
   output nlb_pkg::csr_data_t   num_writes
);

   import nlb_pkg::*;

   // --------------------
   // Request issue
   // --------------------

   // Accept only while the host channel has room
   // Engine sees the accept in the same cycle and advances
   always_comb
   begin
      rd_sent = req.rd_en && !rd_alm_full;
      wr_sent = req.wr_en && !wr_alm_full;
   end

   // Read channel, visible at the port one cycle after accept
   always_ff @(posedge Clk_400)
   begin
      if (rd_sent)
      begin
         tx_rd.addr <= req.rd_addr;
         tx_rd.tid  <= req.rd_tid;
      end
      if (reset)
         tx_rd.valid <= 1'b0;
      else
         tx_rd.valid <= rd_sent;
   end

   // Write channel, same timing
   always_ff @(posedge Clk_400)
   begin
      if (wr_sent)
      begin
         tx_wr.addr <= req.wr_addr;
         tx_wr.tid  <= req.wr_tid;
         tx_wr.data <= req.wr_data;
      end
      if (reset)
         tx_wr.valid <= 1'b0;
      else
         tx_wr.valid <= wr_sent;
   end

   // --------------------
   // Response path
   // --------------------

   // One register stage before the engine
   always_ff @(posedge Clk_400)
   begin
      rd_rsp.tid  <= rx_rd.tid;
      rd_rsp.data <= rx_rd.data;
      wr_rsp.tid  <= rx_wr.tid;
      if (reset)
      begin
         rd_rsp.valid <= 1'b0;
         wr_rsp.valid <= 1'b0;
      end
      else
      begin
         rd_rsp.valid <= rx_rd.valid;
         wr_rsp.valid <= rx_wr.valid;
      end
   end

   // --------------------
   // Issue counters
   // --------------------

   // Cleared while the test is held in reset through CTL
   always_ff @(posedge Clk_400)
   begin
      if (reset || test_reset)
      begin
         num_reads  <= '0;
         num_writes <= '0;
      end
      else
      begin
         if (rd_sent)
            num_reads <= num_reads + 64'd1;
         if (wr_sent)
            num_writes <= num_writes + 64'd1;
      end
   end

endmodule

// File: nlb_test_engine.sv
`timescale 1ns/100ps

module nlb_test_engine
(
   input  logic                 Clk_400,
   input  logic                 reset,
   input  nlb_pkg::test_cfg_t   cfg,
   output nlb_pkg::engine_req_t req,
   input  logic                 rd_sent,
   input  logic                 wr_sent,
   input  nlb_pkg::rd_rsp_t     rd_rsp,
   input  nlb_pkg::wr_rsp_t     wr_rsp,
   output logic                 running,
   output logic                 test_done
);

   import nlb_pkg::*;

   engine_state_e state;

   // Next line to issue on each channel
   cl_count_t rd_idx;
   cl_count_t wr_idx;

   // Responses seen so far
   cl_count_t rd_cnt;
   cl_count_t wr_cnt;

   // LPBK1 copy buffer, one line deep
   logic      hold_valid;
   req_tid_t  hold_tid;
   cl_data_t  hold_data;

   // Mode decode and progress flags
   logic      is_lpbk;
   logic      need_rd;
   logic      need_wr;
   logic      rd_more;
   logic      wr_more;
   logic      rd_block;
   logic      all_rsp;

   // --------------------
   // Mode decode
   // --------------------

   always_comb
   begin
      is_lpbk = (cfg.mode == MODE_LPBK1);
      need_rd = is_lpbk || (cfg.mode == MODE_READ) || (cfg.mode == MODE_TRPUT);
      need_wr = is_lpbk || (cfg.mode == MODE_WRITE) || (cfg.mode == MODE_TRPUT);
      rd_more = (rd_idx < cfg.num_lines);
      wr_more = (wr_idx < cfg.num_lines);
      // LPBK1 keeps one read in flight and waits for the buffer to drain
      // A response can then never find the buffer full
      rd_block = is_lpbk && (hold_valid || (rd_idx != rd_cnt));
      all_rsp = (!need_rd || (rd_cnt == cfg.num_lines)) &&
                (!need_wr || (wr_cnt == cfg.num_lines));
   end

   // --------------------
   // Request generation
   // --------------------

   // Index only moves on a sent pulse, so the request stays stable until taken
   always_comb
   begin
      req.rd_en   = (state == ST_RUN) && need_rd && rd_more && !rd_block;
      req.rd_addr = cfg.src + cl_addr_t'(rd_idx);
      req.rd_tid  = req_tid_t'(rd_idx);

      if (is_lpbk)
      begin
         // Copy: write back what the read returned
         req.wr_en   = (state == ST_RUN) && hold_valid;
         req.wr_addr = cfg.dst + cl_addr_t'(hold_tid);
         req.wr_tid  = hold_tid;
         req.wr_data = hold_data;
      end
      else
      begin
         // Pattern: every 32-bit word holds the line index
         req.wr_en   = (state == ST_RUN) && need_wr && wr_more;
         req.wr_addr = cfg.dst + cl_addr_t'(wr_idx);
         req.wr_tid  = req_tid_t'(wr_idx);
         req.wr_data = {16{16'h0000, wr_idx}};
      end
   end

   // --------------------
   // Test FSM
   // --------------------

   // run_n low holds the engine in idle
   always_ff @(posedge Clk_400)
   begin
      if (reset || !cfg.run_n)
      begin
         state <= ST_IDLE;
      end
      else
      begin
         case (state)
            ST_IDLE:
            begin
               if (cfg.start)
                  state <= ST_RUN;
            end
            ST_RUN:
            begin
               if (all_rsp)
                  state <= ST_DONE;
            end
            // Leaves only through run_n
            default:
            begin
               state <= ST_DONE;
            end
         endcase
      end
   end

   always_comb
   begin
      running   = (state == ST_RUN);
      test_done = (state == ST_DONE);
   end

   // --------------------
   // Indices and counters
   // --------------------

   always_ff @(posedge Clk_400)
   begin
      if (reset || !cfg.run_n || (state == ST_IDLE))
      begin
         rd_idx     <= '0;
         wr_idx     <= '0;
         rd_cnt     <= '0;
         wr_cnt     <= '0;
         hold_valid <= 1'b0;
      end
      else if (state == ST_RUN)
      begin
         if (rd_sent)
            rd_idx <= rd_idx + 16'd1;
         if (wr_sent && !is_lpbk)
            wr_idx <= wr_idx + 16'd1;
         if (rd_rsp.valid)
            rd_cnt <= rd_cnt + 16'd1;
         if (wr_rsp.valid)
            wr_cnt <= wr_cnt + 16'd1;

         // Buffer fills on a read response, empties when its write goes out
         if (is_lpbk && rd_rsp.valid)
            hold_valid <= 1'b1;
         else if (is_lpbk && wr_sent)
            hold_valid <= 1'b0;
      end
   end

   // Buffer payload
   always_ff @(posedge Clk_400)
   begin
      if (rd_rsp.valid)
      begin
         hold_tid  <= rd_rsp.tid;
         hold_data <= rd_rsp.data;
      end
   end

endmodule

// File: nlb_lpbk.sv
`timescale 1ns/100ps

module nlb_lpbk
(
   input  logic               Clk_400,
   input  logic               reset,
   input  nlb_pkg::mmio_req_t mmio_req,
   output nlb_pkg::mmio_rsp_t mmio_rsp,
   output nlb_pkg::rd_req_t   tx_rd,
   output nlb_pkg::wr_req_t   tx_wr,
   input  nlb_pkg::rd_rsp_t   rx_rd,
   input  nlb_pkg::wr_rsp_t   rx_wr,
   input  logic               rd_alm_full,
   input  logic               wr_alm_full
);

   import nlb_pkg::*;

   // Registered copy of the port reset, used by every block
   logic        reset_q;

   // CSR to engine
   test_cfg_t   cfg;
   logic        running;
   logic        test_done;

   // Engine and requestor
   engine_req_t eng_req;
   logic        rd_sent;
   logic        wr_sent;
   rd_rsp_t     rd_rsp;
   wr_rsp_t     wr_rsp;

   // Requestor counters back to CSR
   csr_data_t   num_reads;
   csr_data_t   num_writes;
   logic        test_reset;

   always_ff @(posedge Clk_400)
   begin
      reset_q <= reset;
   end

   // Counters follow the active-low test reset in CTL
   assign test_reset = ~cfg.run_n;

   // --------------------
   // Blocks
   // --------------------

   nlb_csr u_csr
   (
      .Clk_400    (Clk_400),
      .reset      (reset_q),
      .mmio_req   (mmio_req),
      .mmio_rsp   (mmio_rsp),
      .cfg        (cfg),
      .running    (running),
      .test_done  (test_done),
      .num_reads  (num_reads),
      .num_writes (num_writes)
   );

   nlb_test_engine u_engine
   (
      .Clk_400   (Clk_400),
      .reset     (reset_q),
      .cfg       (cfg),
      .req       (eng_req),
      .rd_sent   (rd_sent),
      .wr_sent   (wr_sent),
      .rd_rsp    (rd_rsp),
      .wr_rsp    (wr_rsp),
      .running   (running),
      .test_done (test_done)
   );

   nlb_requestor u_requestor
   (
      .Clk_400     (Clk_400),
      .reset       (reset_q),
      .req         (eng_req),
      .rd_sent     (rd_sent),
      .wr_sent     (wr_sent),
      .tx_rd       (tx_rd),
      .tx_wr       (tx_wr),
      .rx_rd       (rx_rd),
      .rx_wr       (rx_wr),
      .rd_rsp      (rd_rsp),
      .wr_rsp      (wr_rsp),
      .rd_alm_full (rd_alm_full),
      .wr_alm_full (wr_alm_full),
      .test_reset  (test_reset),
      .num_reads   (num_reads),
      .num_writes  (num_writes)
   );

endmodule

// File: tb_nlb_host.sv
`timescale 1ns/100ps

module tb_nlb_host
(
   input  logic             Clk_400,
   input  logic             reset,
   input  logic             alm_en,
   input  nlb_pkg::rd_req_t tx_rd,
   input  nlb_pkg::wr_req_t tx_wr,
   output nlb_pkg::rd_rsp_t rx_rd,
   output nlb_pkg::wr_rsp_t rx_wr,
   output logic             rd_alm_full,
   output logic             wr_alm_full
);

   import nlb_pkg::*;

   // Outstanding reads, each with its own countdown
   logic     slot_busy [32];
   int       slot_wait [32];
   cl_addr_t slot_addr [32];
   req_tid_t slot_tid  [32];

   integer   seed;

   // Quiet host until the first clock edge
   initial
   begin
      seed = 32'h801e_da1e;
      rx_rd       <= '0;
      rx_wr       <= '0;
      rd_alm_full <= 1'b0;
      wr_alm_full <= 1'b0;
   end

   // --------------------
   // Host behavior
   // --------------------

   always @(posedge Clk_400)
   begin : host_model
      int          i;
      logic        picked;
      logic        placed;
      logic [31:0] r;
      if (reset)
      begin
         for (i = 0; i < 32; i++)
            slot_busy[i] = 1'b0;
         rx_rd.valid <= 1'b0;
         rx_wr.valid <= 1'b0;
         rd_alm_full <= 1'b0;
         wr_alm_full <= 1'b0;
      end
      else
      begin
         picked = 1'b0;
         rx_rd.valid <= 1'b0;
         // One read response per cycle, lowest expired slot wins
         // Random countdowns make the order differ from the request order
         for (i = 0; i < 32; i++)
         begin
            if (slot_busy[i] && (slot_wait[i] == 0) && !picked)
            begin
               rx_rd.valid <= 1'b1;
               rx_rd.tid   <= slot_tid[i];
               // Every word carries the requested line address
               rx_rd.data  <= {16{slot_addr[i]}};
               slot_busy[i] = 1'b0;
               picked = 1'b1;
            end
            else if (slot_busy[i] && (slot_wait[i] != 0))
               slot_wait[i] = slot_wait[i] - 1;
         end

         // New read, answered after 1 to 8 cycles
         placed = 1'b0;
         if (tx_rd.valid)
         begin
            for (i = 0; i < 32; i++)
            begin
               if (!slot_busy[i] && !placed)
               begin
                  slot_busy[i] = 1'b1;
                  slot_wait[i] = $random(seed) & 7;
                  slot_addr[i] = tx_rd.addr;
                  slot_tid[i]  = tx_rd.tid;
                  placed = 1'b1;
               end
            end
         end

         // Every write acked on the next cycle
         rx_wr.valid <= tx_wr.valid;
         rx_wr.tid   <= tx_wr.tid;

         // Back-pressure coin flips
         r = $random(seed);
         rd_alm_full <= alm_en & r[0];
         wr_alm_full <= alm_en & r[1];
      end
   end

endmodule

// File: tb_nlb_lpbk.sv
`timescale 1ns/100ps

module tb_nlb_lpbk;

   import nlb_pkg::*;

   logic         Clk_400;
   logic         reset;
   mmio_req_t    mmio_req;
   mmio_rsp_t    mmio_rsp;
   rd_req_t      tx_rd;
   wr_req_t      tx_wr;
   rd_rsp_t      rx_rd;
   wr_rsp_t      rx_wr;
   logic         rd_alm_full;
   logic         wr_alm_full;
   logic         alm_en;

   // Setup of the test in progress
   test_mode_e   cur_mode;
   cl_addr_t     cur_src;
   cl_addr_t     cur_dst;
   cl_count_t    cur_n;

   // Per-line traffic seen at the host side
   logic         track_clr;
   logic [255:0] rd_seen;
   logic [255:0] wr_seen;
   logic [255:0] rsp_seen;
   cl_count_t    rd_total;
   cl_count_t    wr_total;
   cl_data_t     exp_wr_data;
   mmio_tid_t    next_tid;

   nlb_lpbk dut
   (
      .Clk_400     (Clk_400),
      .reset       (reset),
      .mmio_req    (mmio_req),
      .mmio_rsp    (mmio_rsp),
      .tx_rd       (tx_rd),
      .tx_wr       (tx_wr),
      .rx_rd       (rx_rd),
      .rx_wr       (rx_wr),
      .rd_alm_full (rd_alm_full),
      .wr_alm_full (wr_alm_full)
   );

   tb_nlb_host u_host
   (
      .Clk_400     (Clk_400),
      .reset       (reset),
      .alm_en      (alm_en),
      .tx_rd       (tx_rd),
      .tx_wr       (tx_wr),
      .rx_rd       (rx_rd),
      .rx_wr       (rx_wr),
      .rd_alm_full (rd_alm_full),
      .wr_alm_full (wr_alm_full)
   );

   initial
   begin
      Clk_400 = 1'b0;
      forever #20 Clk_400 = ~Clk_400;
   end

   // --------------------
   // Failure reporting
   // --------------------

   task automatic stop_with(input string line);
      $display("%s", line);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic value_error(input string msg);
      stop_with($sformatf("[ERROR] %0t: %s", $time, msg));
   endtask

   // --------------------
   // Traffic tracking
   // --------------------

   always @(posedge Clk_400)
   begin
      if (track_clr)
      begin
         rd_seen  <= '0;
         wr_seen  <= '0;
         rsp_seen <= '0;
         rd_total <= '0;
         wr_total <= '0;
      end
      else
      begin
         if (tx_rd.valid)
         begin
            rd_seen[tx_rd.tid[7:0]] <= 1'b1;
            rd_total <= rd_total + 16'd1;
         end
         if (tx_wr.valid)
         begin
            wr_seen[tx_wr.tid[7:0]] <= 1'b1;
            wr_total <= wr_total + 16'd1;
         end
         if (rx_rd.valid)
            rsp_seen[rx_rd.tid[7:0]] <= 1'b1;
      end
   end

   // Copy returns the host line for src + i, otherwise every word is i
   always_comb
   begin
      if (cur_mode == MODE_LPBK1)
         exp_wr_data = {16{cur_src + cl_addr_t'(tx_wr.tid)}};
      else
         exp_wr_data = {16{32'(tx_wr.tid)}};
   end

   // --------------------
   // Port checks
   // --------------------

   a_rsp_timing: assert property (@(posedge Clk_400) disable iff (reset)
      mmio_req.rd_valid |=> mmio_rsp.valid && (mmio_rsp.tid == $past(mmio_req.tid)))
      else value_error("MMIO response missing one cycle after read, or tid differs");
   a_rsp_origin: assert property (@(posedge Clk_400) disable iff (reset)
      mmio_rsp.valid |-> $past(mmio_req.rd_valid))
      else value_error("MMIO response without a read one cycle before");
   a_rd_mode: assert property (@(posedge Clk_400) disable iff (reset)
      tx_rd.valid |-> (cur_mode != MODE_WRITE))
      else value_error("read issued in WRITE mode");
   a_rd_line: assert property (@(posedge Clk_400) disable iff (reset)
      tx_rd.valid |-> (tx_rd.tid < cur_n) && (tx_rd.addr == cur_src + cl_addr_t'(tx_rd.tid)))
      else value_error("read address or tid outside the configured lines");
   a_rd_once: assert property (@(posedge Clk_400) disable iff (reset)
      tx_rd.valid |-> !rd_seen[tx_rd.tid[7:0]])
      else value_error("line read twice");
   a_wr_mode: assert property (@(posedge Clk_400) disable iff (reset)
      tx_wr.valid |-> (cur_mode != MODE_READ))
      else value_error("write issued in READ mode");
   a_wr_line: assert property (@(posedge Clk_400) disable iff (reset)
      tx_wr.valid |-> (tx_wr.tid < cur_n) && (tx_wr.addr == cur_dst + cl_addr_t'(tx_wr.tid)))
      else value_error("write address or tid outside the configured lines");
   a_wr_once: assert property (@(posedge Clk_400) disable iff (reset)
      tx_wr.valid |-> !wr_seen[tx_wr.tid[7:0]])
      else value_error("line written twice");
   a_wr_data: assert property (@(posedge Clk_400) disable iff (reset)
      tx_wr.valid |-> (tx_wr.data == exp_wr_data))
      else value_error("write data does not match the expected line");
   a_wr_after_rsp: assert property (@(posedge Clk_400) disable iff (reset)
      tx_wr.valid && (cur_mode == MODE_LPBK1) |-> rsp_seen[tx_wr.tid[7:0]])
      else value_error("copy write ahead of its read response");
   a_rd_alm: assert property (@(posedge Clk_400) disable iff (reset)
      $past(rd_alm_full) |-> !tx_rd.valid)
      else value_error("read issued after rd_alm_full");
   a_wr_alm: assert property (@(posedge Clk_400) disable iff (reset)
      $past(wr_alm_full) |-> !tx_wr.valid)
      else value_error("write issued after wr_alm_full");

   // --------------------
   // MMIO tasks
   // --------------------

   task automatic mmio_write(input csr_addr_t addr, input csr_data_t data);
      @(posedge Clk_400);
      mmio_req.wr_valid <= 1'b1;
      mmio_req.addr     <= addr;
      mmio_req.data     <= data;
      @(posedge Clk_400);
      mmio_req.wr_valid <= 1'b0;
   endtask

   // Response sampled at the falling edge, away from the DUT update
   task automatic mmio_read(input csr_addr_t addr, output csr_data_t data);
      int waited;
      @(posedge Clk_400);
      mmio_req.rd_valid <= 1'b1;
      mmio_req.addr     <= addr;
      mmio_req.tid      <= next_tid;
      next_tid          <= next_tid + 9'd1;
      @(posedge Clk_400);
      mmio_req.rd_valid <= 1'b0;
      data = '0;
      for (waited = 0; waited < 8; waited++)
      begin
         @(negedge Clk_400);
         if (mmio_rsp.valid)
            break;
      end
      if (!mmio_rsp.valid)
         stop_with("Timeout: an MMIO read got no response");
      else
         data = mmio_rsp.data;
   endtask

   task automatic check_csr(input csr_addr_t addr, input csr_data_t exp, input string what);
      csr_data_t got;
      mmio_read(addr, got);
      assert (got == exp)
         else value_error($sformatf("%s read 0x%0h, expected 0x%0h", what, got, exp));
   endtask

   // --------------------
   // Test sequencing
   // --------------------

   task automatic start_test(input test_mode_e mode, input cl_addr_t src, input cl_addr_t dst,
                             input cl_count_t n, input logic alm);
      mmio_write(CSR_CTL, 64'd0);
      @(posedge Clk_400);
      cur_mode  <= mode;
      cur_src   <= src;
      cur_dst   <= dst;
      cur_n     <= n;
      alm_en    <= alm;
      track_clr <= 1'b1;
      @(posedge Clk_400);
      track_clr <= 1'b0;
      mmio_write(CSR_SRC_ADDR, 64'(src));
      mmio_write(CSR_DST_ADDR, 64'(dst));
      mmio_write(CSR_NUM_LINES, 64'(n));
      mmio_write(CSR_CFG, {59'h0, mode, 2'b00});
      // run_n and start together
      mmio_write(CSR_CTL, 64'h3);
   endtask

   // Poll STATUS bit 0, then compare the line totals
   task automatic finish_test();
      csr_data_t status;
      cl_count_t exp_rd;
      cl_count_t exp_wr;
      int        polls;
      status = '0;
      for (polls = 0; polls < 500; polls++)
      begin
         mmio_read(CSR_STATUS, status);
         if (status[0])
            break;
      end
      if (!status[0])
         stop_with("Timeout: the test never set its completion flag");
      else
      begin
         exp_rd = (cur_mode == MODE_WRITE) ? 16'd0 : cur_n;
         exp_wr = (cur_mode == MODE_READ) ? 16'd0 : cur_n;
         assert (rd_total == exp_rd)
            else value_error($sformatf("%0d reads seen, expected %0d", rd_total, exp_rd));
         assert (wr_total == exp_wr)
            else value_error($sformatf("%0d writes seen, expected %0d", wr_total, exp_wr));
         check_csr(CSR_NUM_READS, 64'(exp_rd), "NUM_READS");
         check_csr(CSR_NUM_WRITES, 64'(exp_wr), "NUM_WRITES");
         @(posedge Clk_400);
         alm_en <= 1'b0;
      end
   endtask

   initial
   begin
      reset     <= 1'b1;
      mmio_req  <= '0;
      alm_en    <= 1'b0;
      track_clr <= 1'b1;
      cur_mode  <= MODE_LPBK1;
      cur_src   <= '0;
      cur_dst   <= '0;
      cur_n     <= '0;
      next_tid  <= '0;
      repeat (4) @(posedge Clk_400);
      reset     <= 1'b0;
      track_clr <= 1'b0;

      // Scratchpad round trip
      mmio_write(CSR_SCRATCH, 64'h0123_4567_89ab_cdef);
      check_csr(CSR_SCRATCH, 64'h0123_4567_89ab_cdef, "SCRATCH");
      mmio_write(CSR_SCRATCH, 64'hfeed_0000_5a5a_a5a5);
      check_csr(CSR_SCRATCH, 64'hfeed_0000_5a5a_a5a5, "SCRATCH");

      start_test(MODE_READ, 32'h0000_1000, 32'h0000_8000, 16'd16, 1'b0);
      finish_test();
      start_test(MODE_WRITE, 32'h0000_2000, 32'h0000_9000, 16'd12, 1'b0);
      finish_test();
      start_test(MODE_LPBK1, 32'h0003_0040, 32'h0006_0000, 16'd10, 1'b0);
      finish_test();

      // Throughput under back-pressure, with a locked write mid-run
      start_test(MODE_TRPUT, 32'h0004_0000, 32'h0005_0000, 16'd48, 1'b1);
      mmio_write(CSR_NUM_LINES, 64'd5);
      check_csr(CSR_NUM_LINES, 64'd48, "NUM_LINES while running");
      finish_test();

      // Test reset clears flag and counters
      mmio_write(CSR_CTL, 64'd0);
      check_csr(CSR_STATUS, 64'd0, "STATUS after test reset");
      check_csr(CSR_NUM_READS, 64'd0, "NUM_READS after test reset");
      check_csr(CSR_NUM_WRITES, 64'd0, "NUM_WRITES after test reset");

      $display("Simulation passed");
      $finish;
   end

endmodule

// File: compile.f
nlb_pkg.sv
nlb_csr.sv
nlb_requestor.sv
nlb_test_engine.sv
nlb_lpbk.sv
tb_nlb_host.sv
tb_nlb_lpbk.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_nlb_lpbk
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
